//--- cpu_mem_config.svh
//////////////////////////////////////////////////////////////
// memory side configuration: fetch queue, reset vector and
// the memory mapped I/O window
//////////////////////////////////////////////////////////////
`ifndef CPU_MEM_CONFIG_SVH
`define CPU_MEM_CONFIG_SVH

// instruction queue entries
`define IQ_DEPTH 4

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// address bits 17:16 with this value select I/O
`define IO_REGION 2'b11

// byte output port
`define IO_OUT_ADDR 32'h0003_0000

`endif

//--- cpu_mem_pkg.sv
//////////////////////////////////////////////////////////////
// shared types of the fetch and load/store memory path
//////////////////////////////////////////////////////////////
package cpu_mem_pkg;

    // byte address on the core side and on the memory bus
    typedef logic [31:0] addr_t;

    // load/store data word
    typedef logic [31:0] data_t;

    // instruction word
    typedef logic [31:0] inst_t;

    // one byte of the memory bus
    typedef logic [7:0] byte_t;

    // access length in bytes, 1 2 or 4
    typedef logic [2:0] len_t;

    // load/store kinds of RV32I
    typedef enum logic [2:0] {
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW
    } ls_op_e;

    // memory controller states
    typedef enum logic [1:0] {
        MC_IDLE,
        MC_DATA,
        MC_FETCH
    } mc_state_e;

endpackage

//--- fetch_unit.sv
//////////////////////////////////////////////////////////////
// fetch_unit: sequential PC, instruction queue and redirect
//////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "cpu_mem_config.svh"

module fetch_unit #(
    parameter int IQ_DEPTH = `IQ_DEPTH
) (
    input  logic               clk_in,
    input  logic               rst_n,
    input  logic               rdy_in,
    input  logic               jump_en,
    input  cpu_mem_pkg::addr_t jump_pc,
    input  logic               inst_rd,
    input  logic               if_done,
    input  cpu_mem_pkg::inst_t if_inst,
    output logic               if_req,
    output cpu_mem_pkg::addr_t if_addr,
    output cpu_mem_pkg::inst_t inst,
    output cpu_mem_pkg::addr_t inst_pc,
    output logic               inst_empty
);
    import cpu_mem_pkg::*;

    localparam int PTR_W = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(IQ_DEPTH + 1);

    inst_t            inst_mem [IQ_DEPTH];
    addr_t            pc_mem   [IQ_DEPTH];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [CNT_W-1:0] count_q;
    addr_t            pc_q;
    addr_t            req_addr_q;
    logic             req_q;
    logic             discard_q;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        ptr_inc = (p == PTR_W'(IQ_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // a word returned after a redirect belongs to the old path
    assign push = if_done && !discard_q && !jump_en;
    assign pop  = inst_rd && (count_q != '0) && !jump_en;

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            head_q     <= '0;
            tail_q     <= '0;
            count_q    <= '0;
            pc_q       <= `RESET_PC;
            req_addr_q <= `RESET_PC;
            req_q      <= 1'b0;
            discard_q  <= 1'b0;
        end else if (rdy_in) begin
            if (jump_en) begin
                head_q    <= '0;
                tail_q    <= '0;
                count_q   <= '0;
                pc_q      <= jump_pc;
                discard_q <= req_q && !if_done;
            end else begin
                if (push) begin
                    tail_q <= ptr_inc(tail_q);
                    pc_q   <= req_addr_q + 32'd4;
                end
                if (pop) begin
                    head_q <= ptr_inc(head_q);
                end
                if (push != pop) begin
                    count_q <= push ? count_q + 1'b1 : count_q - 1'b1;
                end
                if (if_done) begin
                    discard_q <= 1'b0;
                end
            end
            // one request at a time, only with a free slot
            if (if_done) begin
                req_q <= 1'b0;
            end else if (!req_q && !jump_en && (count_q < CNT_W'(IQ_DEPTH))) begin
                req_q      <= 1'b1;
                req_addr_q <= pc_q;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy_in && push) begin
            inst_mem[tail_q] <= if_inst;
            pc_mem[tail_q]   <= req_addr_q;
        end
    end

    assign if_req     = req_q;
    assign if_addr    = req_addr_q;
    assign inst       = inst_mem[head_q];
    assign inst_pc    = pc_mem[head_q];
    assign inst_empty = (count_q == '0);

    // consumer never reads an empty queue
    a_no_rd_empty: assert property (@(posedge clk_in) disable iff (!rst_n)
        rdy_in && inst_rd |-> !inst_empty);

    // returned word always finds the slot held for it
    a_no_overflow: assert property (@(posedge clk_in) disable iff (!rst_n)
        rdy_in && push |-> count_q < CNT_W'(IQ_DEPTH));

endmodule

//--- lsu.sv
//////////////////////////////////////////////////////////////
// lsu: holds one load/store, sizes it and extends load data
//////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module lsu (
    input  logic                clk_in,
    input  logic                rst_n,
    input  logic                rdy_in,
    input  logic                ls_en,
    input  cpu_mem_pkg::ls_op_e ls_op,
    input  cpu_mem_pkg::addr_t  ls_addr,
    input  cpu_mem_pkg::data_t  ls_wdata,
    output logic                ls_busy,
    output logic                ls_done,
    output cpu_mem_pkg::data_t  ls_rdata,
    output logic                dc_req,
    output logic                dc_store,
    output cpu_mem_pkg::len_t   dc_len,
    output cpu_mem_pkg::addr_t  dc_addr,
    output cpu_mem_pkg::data_t  dc_wdata,
    input  logic                dc_done,
    input  cpu_mem_pkg::data_t  dc_rdata
);
    import cpu_mem_pkg::*;

    ls_op_e op_q;
    addr_t  addr_q;
    data_t  wdata_q;
    data_t  rdata_q;
    logic   busy_q;
    logic   done_q;
    data_t  load_ext;

    function automatic len_t op_len(input ls_op_e op);
        case (op)
            LB, LBU, SB: op_len = 3'd1;
            LH, LHU, SH: op_len = 3'd2;
            default:     op_len = 3'd4;
        endcase
    endfunction

    // result as seen by the core
    always_comb begin
        case (op_q)
            LB:      load_ext = {{24{dc_rdata[7]}}, dc_rdata[7:0]};
            LH:      load_ext = {{16{dc_rdata[15]}}, dc_rdata[15:0]};
            LW:      load_ext = dc_rdata;
            LBU:     load_ext = {24'd0, dc_rdata[7:0]};
            LHU:     load_ext = {16'd0, dc_rdata[15:0]};
            default: load_ext = '0;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else if (rdy_in) begin
            done_q <= 1'b0;
            if (busy_q) begin
                if (dc_done) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end else if (ls_en) begin
                busy_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy_in) begin
            if (!busy_q && ls_en) begin
                op_q    <= ls_op;
                addr_q  <= ls_addr;
                wdata_q <= ls_wdata;
            end
            if (busy_q && dc_done) begin
                rdata_q <= load_ext;
            end
        end
    end

    assign ls_busy  = busy_q;
    assign ls_done  = done_q && rdy_in;
    assign ls_rdata = rdata_q;

    // request stays up until the controller answers
    assign dc_req   = busy_q;
    assign dc_store = (op_q == SB) || (op_q == SH) || (op_q == SW);
    assign dc_len   = op_len(op_q);
    assign dc_addr  = addr_q;
    assign dc_wdata = wdata_q;

    a_no_en_busy: assert property (@(posedge clk_in) disable iff (!rst_n)
        rdy_in && ls_en |-> !ls_busy);

    // halfwords on even addresses and words on multiples of 4
    a_aligned: assert property (@(posedge clk_in) disable iff (!rst_n)
        rdy_in && ls_en |-> (ls_addr[1:0] & 2'(op_len(ls_op) - 3'd1)) == 2'b00);

endmodule

//--- mem_ctrl.sv
//////////////////////////////////////////////////////////////
// mem_ctrl: shares the byte-wide memory port between fetch
// and data, data first, little-endian byte assembly
//////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "cpu_mem_config.svh"

module mem_ctrl (
    input  logic               clk_in,
    input  logic               rst_n,
    input  logic               rdy_in,
    input  logic               io_buffer_full,
    input  cpu_mem_pkg::byte_t mem_din,
    output cpu_mem_pkg::byte_t mem_dout,
    output cpu_mem_pkg::addr_t mem_a,
    output logic               mem_wr,
    input  logic               if_req,
    input  cpu_mem_pkg::addr_t if_addr,
    output logic               if_done,
    output cpu_mem_pkg::inst_t if_inst,
    input  logic               dc_req,
    input  logic               dc_store,
    input  cpu_mem_pkg::len_t  dc_len,
    input  cpu_mem_pkg::addr_t dc_addr,
    input  cpu_mem_pkg::data_t dc_wdata,
    output logic               dc_done,
    output cpu_mem_pkg::data_t dc_rdata
);
    import cpu_mem_pkg::*;

    mc_state_e  state_q;
    // cycles since acceptance, byte k is on the bus in cycle k
    len_t       cnt_q;
    len_t       len_q;
    logic       store_q;
    addr_t      addr_q;
    // write data on stores, read bytes land here on loads and fetches
    data_t      asm_q;
    logic       if_done_q;
    logic       dc_done_q;
    logic       io_stall;
    logic       step;
    logic       accept_dc;
    logic       accept_if;
    logic       finish;
    logic [1:0] rd_lane;

    // UART side cannot take the byte yet
    assign io_stall = (state_q == MC_DATA) && store_q &&
                      (addr_q[17:16] == `IO_REGION) && io_buffer_full;
    assign step     = rdy_in && !io_stall;

    // requester still holds req during its done cycle
    assign accept_dc = (state_q == MC_IDLE) && dc_req && !dc_done_q;
    assign accept_if = (state_q == MC_IDLE) && !accept_dc && if_req && !if_done_q;

    // reads need one extra cycle for the last byte to come back
    assign finish = (state_q != MC_IDLE) &&
                    (store_q ? (cnt_q == len_q - 3'd1) : (cnt_q == len_q));

    // byte on mem_din was addressed one cycle earlier
    assign rd_lane = cnt_q[1:0] - 2'd1;

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            state_q   <= MC_IDLE;
            cnt_q     <= '0;
            store_q   <= 1'b0;
            addr_q    <= '0;
            if_done_q <= 1'b0;
            dc_done_q <= 1'b0;
        end else if (step) begin
            if_done_q <= 1'b0;
            dc_done_q <= 1'b0;
            case (state_q)
                MC_IDLE: begin
                    cnt_q <= '0;
                    if (accept_dc) begin
                        state_q <= MC_DATA;
                        store_q <= dc_store;
                        addr_q  <= dc_addr;
                    end else if (accept_if) begin
                        state_q <= MC_FETCH;
                        store_q <= 1'b0;
                        addr_q  <= if_addr;
                    end
                end
                default: begin
                    cnt_q <= cnt_q + 3'd1;
                    if (finish) begin
                        state_q   <= MC_IDLE;
                        store_q   <= 1'b0;
                        if_done_q <= (state_q == MC_FETCH);
                        dc_done_q <= (state_q == MC_DATA);
                    end else if (cnt_q < len_q - 3'd1) begin
                        addr_q <= addr_q + 32'd1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (step) begin
            if (accept_dc) begin
                len_q <= dc_len;
                asm_q <= dc_store ? dc_wdata : '0;
            end else if (accept_if) begin
                len_q <= 3'd4;
                asm_q <= '0;
            end else if (state_q != MC_IDLE && !store_q && cnt_q != 3'd0) begin
                asm_q[{rd_lane, 3'b000} +: 8] <= mem_din;
            end
        end
    end

    assign mem_a    = addr_q;
    assign mem_dout = asm_q[{cnt_q[1:0], 3'b000} +: 8];
    assign mem_wr   = (state_q == MC_DATA) && store_q && step;

    // done pulses only show in running cycles
    assign if_done  = if_done_q && rdy_in;
    assign dc_done  = dc_done_q && rdy_in;
    assign if_inst  = asm_q;
    assign dc_rdata = asm_q;

    // a paused cycle writes nothing and moves no bus state
    a_no_wr_paused: assert property (@(posedge clk_in) disable iff (!rst_n)
        !rdy_in |-> !mem_wr ##1 ($stable(state_q) && $stable(cnt_q) && $stable(addr_q)));

endmodule

//--- cpu_mem_top.sv
//////////////////////////////////////////////////////////////
// cpu_mem_top: fetch, load/store and memory controller
//////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module cpu_mem_top (
    input  logic                clk_in,
    input  logic                rst_n,
    input  logic                rdy_in,
    input  cpu_mem_pkg::byte_t  mem_din,
    output cpu_mem_pkg::byte_t  mem_dout,
    output cpu_mem_pkg::addr_t  mem_a,
    output logic                mem_wr,
    input  logic                io_buffer_full,
    input  logic                jump_en,
    input  cpu_mem_pkg::addr_t  jump_pc,
    input  logic                inst_rd,
    output cpu_mem_pkg::inst_t  inst,
    output cpu_mem_pkg::addr_t  inst_pc,
    output logic                inst_empty,
    input  logic                ls_en,
    input  cpu_mem_pkg::ls_op_e ls_op,
    input  cpu_mem_pkg::addr_t  ls_addr,
    input  cpu_mem_pkg::data_t  ls_wdata,
    output logic                ls_busy,
    output logic                ls_done,
    output cpu_mem_pkg::data_t  ls_rdata
);
    import cpu_mem_pkg::*;

    // fetch side of the controller
    logic  if_req;
    addr_t if_addr;
    logic  if_done;
    inst_t if_inst;

    // data side of the controller
    logic  dc_req;
    logic  dc_store;
    len_t  dc_len;
    addr_t dc_addr;
    data_t dc_wdata;
    logic  dc_done;
    data_t dc_rdata;

    fetch_unit fetch_unit_inst (
        .clk_in     (clk_in),
        .rst_n      (rst_n),
        .rdy_in     (rdy_in),
        .jump_en    (jump_en),
        .jump_pc    (jump_pc),
        .inst_rd    (inst_rd),
        .if_done    (if_done),
        .if_inst    (if_inst),
        .if_req     (if_req),
        .if_addr    (if_addr),
        .inst       (inst),
        .inst_pc    (inst_pc),
        .inst_empty (inst_empty)
    );

    lsu lsu_inst (
        .clk_in   (clk_in),
        .rst_n    (rst_n),
        .rdy_in   (rdy_in),
        .ls_en    (ls_en),
        .ls_op    (ls_op),
        .ls_addr  (ls_addr),
        .ls_wdata (ls_wdata),
        .ls_busy  (ls_busy),
        .ls_done  (ls_done),
        .ls_rdata (ls_rdata),
        .dc_req   (dc_req),
        .dc_store (dc_store),
        .dc_len   (dc_len),
        .dc_addr  (dc_addr),
        .dc_wdata (dc_wdata),
        .dc_done  (dc_done),
        .dc_rdata (dc_rdata)
    );

    mem_ctrl mem_ctrl_inst (
        .clk_in         (clk_in),
        .rst_n          (rst_n),
        .rdy_in         (rdy_in),
        .io_buffer_full (io_buffer_full),
        .mem_din        (mem_din),
        .mem_dout       (mem_dout),
        .mem_a          (mem_a),
        .mem_wr         (mem_wr),
        .if_req         (if_req),
        .if_addr        (if_addr),
        .if_done        (if_done),
        .if_inst        (if_inst),
        .dc_req         (dc_req),
        .dc_store       (dc_store),
        .dc_len         (dc_len),
        .dc_addr        (dc_addr),
        .dc_wdata       (dc_wdata),
        .dc_done        (dc_done),
        .dc_rdata       (dc_rdata)
    );

endmodule

//--- tb_mem_model.sv
//////////////////////////////////////////////////////////////
// testbench memory: 128 KB RAM, next-cycle reads, I/O log
//////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "cpu_mem_config.svh"

module tb_mem_model (
    input  logic               clk_in,
    input  logic               rdy_in,
    input  cpu_mem_pkg::addr_t mem_a,
    input  cpu_mem_pkg::byte_t mem_dout,
    input  logic               mem_wr,
    output cpu_mem_pkg::byte_t mem_din
);
    import cpu_mem_pkg::*;

    localparam int RAM_BYTES = 131072;

    byte_t  ram [0:RAM_BYTES-1];
    // bytes written to the output port, in order
    byte_t  io_log [$];
    byte_t  rd_q = 8'h00;
    integer seed;
    logic   is_io;

    initial begin
        seed = 32'h0985_d981;
        for (int i = 0; i < RAM_BYTES; i++) begin
            ram[i] = byte_t'($random(seed));
        end
    end

    assign is_io = (mem_a[17:16] == `IO_REGION);

    // paused cycles keep the last read byte on the bus
    always @(posedge clk_in) begin
        if (rdy_in) begin
            if (mem_wr) begin
                if (is_io) begin
                    io_log.push_back(mem_dout);
                end else begin
                    ram[mem_a[16:0]] <= mem_dout;
                end
            end else if (is_io) begin
                rd_q <= 8'h00;
            end else begin
                rd_q <= ram[mem_a[16:0]];
            end
        end
    end

    assign mem_din = rd_q;

endmodule

//--- tb_cpu_mem.sv
//////////////////////////////////////////////////////////////
// testbench of the fetch and load/store memory path
//////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "cpu_mem_config.svh"

module tb_cpu_mem;
    import cpu_mem_pkg::*;

    localparam int RAM_BYTES = 131072;
    localparam int LIMIT     = 2000;

    logic   clk_in = 1'b0;
    logic   rst_n;
    logic   rdy_in;
    logic   io_buffer_full;
    byte_t  mem_din;
    byte_t  mem_dout;
    addr_t  mem_a;
    logic   mem_wr;
    logic   jump_en;
    addr_t  jump_pc;
    logic   inst_rd;
    inst_t  inst;
    addr_t  inst_pc;
    logic   inst_empty;
    logic   ls_en;
    ls_op_e ls_op;
    addr_t  ls_addr;
    data_t  ls_wdata;
    logic   ls_busy;
    logic   ls_done;
    data_t  ls_rdata;

    // reference state
    byte_t  shadow [0:RAM_BYTES-1];
    byte_t  io_expect [$];
    addr_t  exp_pc;
    data_t  exp_rdata;
    int     errors = 0;
    integer fill_seed;
    integer rdy_seed;
    integer stim_seed;

    always #50 clk_in = ~clk_in;

    cpu_mem_top cpu_mem_top_inst (
        .clk_in(clk_in), .rst_n(rst_n), .rdy_in(rdy_in),
        .mem_din(mem_din), .mem_dout(mem_dout), .mem_a(mem_a), .mem_wr(mem_wr),
        .io_buffer_full(io_buffer_full), .jump_en(jump_en), .jump_pc(jump_pc),
        .inst_rd(inst_rd), .inst(inst), .inst_pc(inst_pc), .inst_empty(inst_empty),
        .ls_en(ls_en), .ls_op(ls_op), .ls_addr(ls_addr), .ls_wdata(ls_wdata),
        .ls_busy(ls_busy), .ls_done(ls_done), .ls_rdata(ls_rdata)
    );

    tb_mem_model mem_model_inst (
        .clk_in(clk_in), .rdy_in(rdy_in), .mem_a(mem_a),
        .mem_dout(mem_dout), .mem_wr(mem_wr), .mem_din(mem_din)
    );

    function automatic data_t shadow_word(input addr_t a);
        shadow_word = {shadow[a[16:0] + 3], shadow[a[16:0] + 2],
                       shadow[a[16:0] + 1], shadow[a[16:0]]};
    endfunction

    function automatic logic is_store(input ls_op_e op);
        is_store = (op == SB) || (op == SH) || (op == SW);
    endfunction

    // little-endian bytes, then sign or zero extension
    function automatic data_t load_expect(input ls_op_e op, input addr_t a);
        data_t w;
        w = shadow_word(a);
        case (op)
            LB:      load_expect = {{24{w[7]}}, w[7:0]};
            LH:      load_expect = {{16{w[15]}}, w[15:0]};
            LBU:     load_expect = {24'd0, w[7:0]};
            LHU:     load_expect = {16'd0, w[15:0]};
            default: load_expect = w;
        endcase
    endfunction

    task automatic update_shadow(input ls_op_e op, input addr_t a, input data_t d);
        int n;
        n = (op == SB) ? 1 : ((op == SH) ? 2 : 4);
        for (int k = 0; k < n; k++) begin
            shadow[a[16:0] + k] = d[8*k +: 8];
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        $display("TEST FAILED");
        $finish;
    endtask

    // returns at a negedge of a cycle in which rdy_in is high
    task automatic wait_rdy_cycle(input string what);
        int n;
        n = 0;
        @(negedge clk_in);
        while (!rdy_in && n < LIMIT) begin
            @(negedge clk_in);
            n++;
        end
        if (n >= LIMIT) stop_on_timeout(what);
    endtask

    task automatic do_ls(input ls_op_e op, input addr_t a, input data_t d);
        int n;
        @(posedge clk_in);
        ls_en    <= 1'b1;
        ls_op    <= op;
        ls_addr  <= a;
        ls_wdata <= d;
        exp_rdata <= is_store(op) ? 32'd0 : load_expect(op, a);
        // I/O stores never reach the RAM
        if (is_store(op) && a[17:16] != `IO_REGION) update_shadow(op, a, d);
        wait_rdy_cycle("load/store acceptance");
        @(posedge clk_in);
        ls_en <= 1'b0;
        n = 0;
        @(negedge clk_in);
        while (!ls_done && n < LIMIT) begin
            @(negedge clk_in);
            n++;
        end
        if (n >= LIMIT) stop_on_timeout("ls_done");
    endtask

    task automatic read_inst();
        int n;
        n = 0;
        @(negedge clk_in);
        while (inst_empty && n < LIMIT) begin
            @(negedge clk_in);
            n++;
        end
        if (n >= LIMIT) stop_on_timeout("an instruction");
        @(posedge clk_in);
        inst_rd <= 1'b1;
        wait_rdy_cycle("inst_rd acceptance");
        @(posedge clk_in);
        inst_rd <= 1'b0;
    endtask

    task automatic jump_to(input addr_t pc);
        @(posedge clk_in);
        jump_en <= 1'b1;
        jump_pc <= pc;
        wait_rdy_cycle("jump acceptance");
        @(posedge clk_in);
        jump_en <= 1'b0;
    endtask

    // pc of the next instruction the consumer should see
    always @(posedge clk_in) begin
        if (!rst_n) begin
            exp_pc <= `RESET_PC;
        end else if (rdy_in) begin
            if (jump_en) exp_pc <= jump_pc;
            else if (inst_rd) exp_pc <= exp_pc + 32'd4;
        end
    end

    always @(posedge clk_in) begin
        rdy_in         <= ($random(rdy_seed) & 3) != 0;
        io_buffer_full <= ($random(rdy_seed) & 1) != 0;
    end

    a_fetch_pc: assert property (@(posedge clk_in) disable iff (!rst_n)
        rdy_in && inst_rd |-> inst_pc == exp_pc)
        else begin
            errors++;
            $display("Fail %0t inst_pc expected %h got %h", $time,
                     $sampled(exp_pc), $sampled(inst_pc));
        end

    a_fetch_word: assert property (@(posedge clk_in) disable iff (!rst_n)
        rdy_in && inst_rd |-> inst == shadow_word(exp_pc))
        else begin
            errors++;
            $display("Fail %0t inst expected %h got %h", $time,
                     shadow_word($sampled(exp_pc)), $sampled(inst));
        end

    a_ls_data: assert property (@(posedge clk_in) disable iff (!rst_n)
        ls_done |-> ls_rdata == exp_rdata)
        else begin
            errors++;
            $display("Fail %0t ls_rdata expected %h got %h", $time,
                     $sampled(exp_rdata), $sampled(ls_rdata));
        end

    a_ls_busy_set: assert property (@(posedge clk_in) disable iff (!rst_n)
        rdy_in && ls_en |=> ls_busy)
        else begin
            errors++;
            $display("Fail %0t ls_busy expected 1 got %b", $time, $sampled(ls_busy));
        end

    a_ls_busy_clear: assert property (@(posedge clk_in) disable iff (!rst_n)
        ls_done |-> !ls_busy)
        else begin
            errors++;
            $display("Fail %0t ls_busy expected 0 got %b", $time, $sampled(ls_busy));
        end

    a_pause_quiet: assert property (@(posedge clk_in) disable iff (!rst_n)
        !rdy_in |-> !mem_wr && !ls_done)
        else begin
            errors++;
            $display("write or ls_done seen while paused at %0t", $time);
        end

    a_pause_addr: assert property (@(posedge clk_in) disable iff (!rst_n)
        !rdy_in |=> $stable(mem_a))
        else begin
            errors++;
            $display("Fail %0t mem_a expected %h got %h", $time,
                     $past(mem_a), $sampled(mem_a));
        end

    a_pause_inst: assert property (@(posedge clk_in) disable iff (!rst_n)
        !rdy_in && inst_empty |=> inst_empty)
        else begin
            errors++;
            $display("instruction became valid while paused at %0t", $time);
        end

    a_io_hold: assert property (@(posedge clk_in) disable iff (!rst_n)
        mem_wr && mem_a[17:16] == `IO_REGION |-> !io_buffer_full)
        else begin
            errors++;
            $display("I/O write while the output buffer was full at %0t", $time);
        end

    initial begin
        ls_op_e op;
        addr_t  a;
        data_t  d;
        fill_seed = 32'h0985_d981;
        rdy_seed  = 32'h0985_d981;
        stim_seed = 32'h0985_d981;
        for (int i = 0; i < RAM_BYTES; i++) begin
            shadow[i] = byte_t'($random(fill_seed));
        end
        rst_n          = 1'b0;
        rdy_in         = 1'b0;
        io_buffer_full = 1'b0;
        jump_en        = 1'b0;
        jump_pc        = '0;
        inst_rd        = 1'b0;
        ls_en          = 1'b0;
        ls_op          = LW;
        ls_addr        = '0;
        ls_wdata       = '0;
        repeat (8) @(posedge clk_in);
        rst_n <= 1'b1;

        // sequential fetch, then redirects with a fetch likely in flight
        repeat (6) read_inst();
        jump_to(32'h0000_0100);
        repeat (5) read_inst();
        jump_to(32'h0000_01f0);
        repeat (3) read_inst();

        // loads of every kind while fetch keeps running
        for (int i = 0; i < 20; i++) begin
            op = ls_op_e'(i % 5);
            a  = 32'h4000 + ($random(stim_seed) & 32'h3fff);
            if (op == LH || op == LHU) a[0] = 1'b0;
            if (op == LW) a[1:0] = 2'b00;
            do_ls(op, a, 32'd0);
            read_inst();
        end

        // store, then read back the word and the stored lanes
        for (int i = 0; i < 12; i++) begin
            op = ls_op_e'(5 + (i % 3));
            a  = 32'h8000 + ($random(stim_seed) & 32'h0fff);
            d  = $random(stim_seed);
            if (op == SH) a[0] = 1'b0;
            if (op == SW) a[1:0] = 2'b00;
            do_ls(op, a, d);
            do_ls(LW, {a[31:2], 2'b00}, 32'd0);
            do_ls((op == SB) ? LBU : ((op == SH) ? LHU : LW), a, 32'd0);
        end

        // byte output port under a randomly full buffer
        for (int i = 0; i < 8; i++) begin
            d = $random(stim_seed);
            io_expect.push_back(d[7:0]);
            do_ls(SB, `IO_OUT_ADDR, d);
        end

        assert (mem_model_inst.io_log.size() == io_expect.size())
            else begin
                errors++;
                $display("Fail %0t io_log size expected %0d got %0d", $time,
                         io_expect.size(), mem_model_inst.io_log.size());
            end
        for (int i = 0; i < io_expect.size() && i < mem_model_inst.io_log.size(); i++) begin
            assert (mem_model_inst.io_log[i] == io_expect[i])
                else begin
                    errors++;
                    $display("Fail %0t io_log[%0d] expected %h got %h", $time, i,
                             io_expect[i], mem_model_inst.io_log[i]);
                end
        end

        repeat (4) @(posedge clk_in);
        $display("checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+.
cpu_mem_pkg.sv
fetch_unit.sv
lsu.sv
mem_ctrl.sv
cpu_mem_top.sv
tb_mem_model.sv
tb_cpu_mem.sv
